/* Bender.yml */
package:
  name: cabinet_inputs

sources:
  - logic/cabinet_ctrl_pkg.sv
  - logic/cabinet_game_pkg.sv
  - logic/ps2_key_decoder.sv
  - logic/db9_split_fsm.sv
  - logic/control_merge.sv
  - logic/gear_counter.sv
  - logic/input_port_map.sv
  - logic/cabinet_inputs.sv
  - target: simulation
    files:
      - verif/cabinet_inputs_properties.sv
      - verif/cabinet_checker.sv
      - verif/tb_cabinet_inputs.sv

/* list.f */
logic/cabinet_ctrl_pkg.sv
logic/cabinet_game_pkg.sv
logic/ps2_key_decoder.sv
logic/db9_split_fsm.sv
logic/control_merge.sv
logic/gear_counter.sv
logic/input_port_map.sv
logic/cabinet_inputs.sv
verif/cabinet_inputs_properties.sv
verif/cabinet_checker.sv
verif/tb_cabinet_inputs.sv

/* logic/cabinet_ctrl_pkg.sv */
/*
 * Player control, DB9 line and keyboard event types shared by the input logic
 * Bit positions below give the layout of each vector
 */
package cabinet_ctrl_pkg;

	typedef logic [9:0]  player_ctrl_t;  // Positive logic, same layout as host pad
	typedef logic [5:0]  db9_lines_t;    // Active low C, B, up, down, left, right
	typedef logic [10:0] ps2_event_t;    // Strobe, pressed, scancode
	typedef logic [7:0]  port_byte_t;    // Active low CPU input byte

	// player_ctrl_t bits
	localparam int BTN_RIGHT  = 0;
	localparam int BTN_LEFT   = 1;
	localparam int BTN_DOWN   = 2;
	localparam int BTN_UP     = 3;
	localparam int BTN_FIRE_A = 4;
	localparam int BTN_FIRE_B = 5;
	localparam int BTN_FIRE_C = 6;
	localparam int BTN_FIRE_D = 7;
	localparam int BTN_START  = 8;
	localparam int BTN_COIN   = 9;

	// db9_lines_t bits
	localparam int DB9_RIGHT = 0;
	localparam int DB9_LEFT  = 1;
	localparam int DB9_DOWN  = 2;
	localparam int DB9_UP    = 3;
	localparam int DB9_B     = 4;
	localparam int DB9_C     = 5;

	// ps2_event_t fields, scancode in bits 8:0
	localparam int PS2_PRESSED = 9;
	localparam int PS2_STROBE  = 10;

endpackage

/* logic/cabinet_game_pkg.sv */
/*
 * Game selection, DB9 mode and gearbox definitions
 * Used by the merge, gear and port mapping logic
 */
package cabinet_game_pkg;

	// Board variant, same numbering as the ROM set index
	typedef enum logic [1:0] {
		RAMPAGE    = 2'd0,
		SARGE      = 2'd1,
		POWERDRIVE = 2'd2,
		MAXRPM     = 2'd3
	} game_e;

	typedef enum logic [1:0] {
		PLAYER1  = 2'd0,  // DB9 drives player 1
		PLAYER2  = 2'd1,  // DB9 drives player 2
		SPLITTER = 2'd2,  // Two sticks through the splitter
		OFF      = 2'd3
	} db9_mode_e;

	typedef logic [2:0] gear_t;

	localparam gear_t GEAR_MAX = 3'd4;

	// Shifter switch pattern seen by the Max RPM CPU, indexed by gear
	localparam logic [3:0] MAXRPM_GEAR_BITS [5] = '{4'h0, 4'h5, 4'h6, 4'h1, 4'h2};

	localparam logic [7:0] PORT_IDLE = 8'hFF;  // Nothing pressed

endpackage

/* logic/cabinet_inputs.sv */
/*
 * Cabinet input block, player controls in and CPU input bytes out
 */
`timescale 1ns/1ps

module cabinet_inputs #(
	parameter int SPLIT_DIV = 16
) (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  cabinet_ctrl_pkg::ps2_event_t   ps2_key_i,
	input  cabinet_ctrl_pkg::player_ctrl_t pad0_i,
	input  cabinet_ctrl_pkg::player_ctrl_t pad1_i,
	input  cabinet_ctrl_pkg::db9_lines_t   db9_i,
	input  cabinet_game_pkg::db9_mode_e    db9_mode_i,
	input  logic                           swap_i,
	input  cabinet_game_pkg::game_e        game_i,
	input  logic                           service_i,
	input  cabinet_ctrl_pkg::port_byte_t   dip_i,
	output logic                           splitter_select_o,
	output cabinet_ctrl_pkg::port_byte_t   input0_o,
	output cabinet_ctrl_pkg::port_byte_t   input1_o,
	output cabinet_ctrl_pkg::port_byte_t   input2_o,
	output cabinet_ctrl_pkg::port_byte_t   input3_o,
	output cabinet_ctrl_pkg::port_byte_t   input4_o
);

	cabinet_ctrl_pkg::player_ctrl_t kbd_p1, kbd_p2;
	cabinet_ctrl_pkg::player_ctrl_t ctrl_p1, ctrl_p2;
	cabinet_ctrl_pkg::db9_lines_t   split_p1, split_p2, db9_reg;
	cabinet_game_pkg::gear_t        maxrpm_gear1, maxrpm_gear2;
	logic [1:0]                     powerdrv_gear;

	// ====================
	// Control sources
	ps2_key_decoder i_kbd (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ps2_key_i (ps2_key_i),
		.kbd_p1_o  (kbd_p1),
		.kbd_p2_o  (kbd_p2)
	);

	db9_split_fsm #(
		.SPLIT_DIV (SPLIT_DIV)
	) i_db9 (
		.clk_sys           (clk_sys),
		.reset             (reset),
		.db9_i             (db9_i),
		.splitter_select_o (splitter_select_o),
		.split_p1_o        (split_p1),
		.split_p2_o        (split_p2),
		.db9_reg_o         (db9_reg)
	);

	control_merge i_merge (
		.db9_mode_i (db9_mode_i),
		.swap_i     (swap_i),
		.db9_reg_i  (db9_reg),
		.split_p1_i (split_p1),
		.split_p2_i (split_p2),
		.kbd_p1_i   (kbd_p1),
		.kbd_p2_i   (kbd_p2),
		.pad0_i     (pad0_i),
		.pad1_i     (pad1_i),
		.ctrl_p1_o  (ctrl_p1),
		.ctrl_p2_o  (ctrl_p2)
	);

	// ====================
	// Game side
	gear_counter i_gears (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.ctrl_p1_i       (ctrl_p1),
		.ctrl_p2_i       (ctrl_p2),
		.maxrpm_gear1_o  (maxrpm_gear1),
		.maxrpm_gear2_o  (maxrpm_gear2),
		.powerdrv_gear_o (powerdrv_gear)
	);

	input_port_map i_ports (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.game_i          (game_i),
		.service_i       (service_i),
		.dip_i           (dip_i),
		.ctrl_p1_i       (ctrl_p1),
		.ctrl_p2_i       (ctrl_p2),
		.maxrpm_gear1_i  (maxrpm_gear1),
		.maxrpm_gear2_i  (maxrpm_gear2),
		.powerdrv_gear_i (powerdrv_gear),
		.input0_o        (input0_o),
		.input1_o        (input1_o),
		.input2_o        (input2_o),
		.input3_o        (input3_o),
		.input4_o        (input4_o)
	);

endmodule

/* logic/control_merge.sv */
/*
 * Per player merge of keyboard, host pad and DB9 stick
 * The DB9 source follows the mode, the swap only touches the DB9 path
 */
`timescale 1ns/1ps

module control_merge (
	input  cabinet_game_pkg::db9_mode_e    db9_mode_i,
	input  logic                           swap_i,
	input  cabinet_ctrl_pkg::db9_lines_t   db9_reg_i,
	input  cabinet_ctrl_pkg::db9_lines_t   split_p1_i,
	input  cabinet_ctrl_pkg::db9_lines_t   split_p2_i,
	input  cabinet_ctrl_pkg::player_ctrl_t kbd_p1_i,
	input  cabinet_ctrl_pkg::player_ctrl_t kbd_p2_i,
	input  cabinet_ctrl_pkg::player_ctrl_t pad0_i,
	input  cabinet_ctrl_pkg::player_ctrl_t pad1_i,
	output cabinet_ctrl_pkg::player_ctrl_t ctrl_p1_o,
	output cabinet_ctrl_pkg::player_ctrl_t ctrl_p2_o
);

	cabinet_ctrl_pkg::db9_lines_t   src_p1;
	cabinet_ctrl_pkg::db9_lines_t   src_p2;
	cabinet_ctrl_pkg::player_ctrl_t db9_p1;
	cabinet_ctrl_pkg::player_ctrl_t db9_p2;
	cabinet_ctrl_pkg::player_ctrl_t joy_p1;  // After swap
	cabinet_ctrl_pkg::player_ctrl_t joy_p2;

	// Stick B and C land on fire A and fire B
	function automatic cabinet_ctrl_pkg::player_ctrl_t db9_to_ctrl(
		input cabinet_ctrl_pkg::db9_lines_t lines
	);
		cabinet_ctrl_pkg::player_ctrl_t ctrl;
		ctrl = '0;
		ctrl[cabinet_ctrl_pkg::BTN_RIGHT]  = ~lines[cabinet_ctrl_pkg::DB9_RIGHT];
		ctrl[cabinet_ctrl_pkg::BTN_LEFT]   = ~lines[cabinet_ctrl_pkg::DB9_LEFT];
		ctrl[cabinet_ctrl_pkg::BTN_DOWN]   = ~lines[cabinet_ctrl_pkg::DB9_DOWN];
		ctrl[cabinet_ctrl_pkg::BTN_UP]     = ~lines[cabinet_ctrl_pkg::DB9_UP];
		ctrl[cabinet_ctrl_pkg::BTN_FIRE_A] = ~lines[cabinet_ctrl_pkg::DB9_B];
		ctrl[cabinet_ctrl_pkg::BTN_FIRE_B] = ~lines[cabinet_ctrl_pkg::DB9_C];
		return ctrl;
	endfunction

	always_comb begin
		src_p1 = '1;
		src_p2 = '1;
		case (db9_mode_i)
			cabinet_game_pkg::PLAYER1:  src_p1 = db9_reg_i;
			cabinet_game_pkg::PLAYER2:  src_p2 = db9_reg_i;
			cabinet_game_pkg::SPLITTER: begin
				src_p1 = split_p1_i;
				src_p2 = split_p2_i;
			end
			default: ;  // OFF, both released
		endcase
	end

	assign db9_p1 = db9_to_ctrl(src_p1);
	assign db9_p2 = db9_to_ctrl(src_p2);
	assign joy_p1 = swap_i ? db9_p2 : db9_p1;
	assign joy_p2 = swap_i ? db9_p1 : db9_p2;

	assign ctrl_p1_o = kbd_p1_i | pad0_i | joy_p1;
	assign ctrl_p2_o = kbd_p2_i | pad1_i | joy_p2;

endmodule

/* logic/db9_split_fsm.sv */
/*
 * DB9 capture with two-player splitter support
 * Alternates the splitter select every SPLIT_DIV cycles and samples each stick
 */
`timescale 1ns/1ps

module db9_split_fsm #(
	parameter int SPLIT_DIV = 16  // Cycles per splitter phase, 2 or more
) (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  cabinet_ctrl_pkg::db9_lines_t db9_i,
	output logic                         splitter_select_o,
	output cabinet_ctrl_pkg::db9_lines_t split_p1_o,
	output cabinet_ctrl_pkg::db9_lines_t split_p2_o,
	output cabinet_ctrl_pkg::db9_lines_t db9_reg_o
);

	localparam int CNT_W = $clog2(SPLIT_DIV);

	typedef enum logic {
		SEL_P1,
		SEL_P2
	} sel_state_e;

	sel_state_e       state_q;
	logic [CNT_W-1:0] div_cnt_q;
	logic             phase_end;

	assign phase_end = (div_cnt_q == CNT_W'(SPLIT_DIV - 1));

	// ====================
	// Prescaler and select FSM
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state_q    <= SEL_P1;
			div_cnt_q  <= '0;
			split_p1_o <= '1;  // Released
			split_p2_o <= '1;
		end else if (phase_end) begin
			div_cnt_q <= '0;
			case (state_q)
				SEL_P1: begin
					split_p1_o <= db9_i;
					state_q    <= SEL_P2;
				end
				SEL_P2: begin
					split_p2_o <= db9_i;
					state_q    <= SEL_P1;
				end
				default: state_q <= SEL_P1;
			endcase
		end else begin
			div_cnt_q <= div_cnt_q + 1'b1;
		end
	end

	assign splitter_select_o = (state_q == SEL_P1);

	// Plain sample for the single stick modes
	always_ff @(posedge clk_sys) begin
		db9_reg_o <= db9_i;
	end

endmodule

/* logic/gear_counter.sv */
/*
 * Gearbox state for Max RPM and Power Drive
 * Fire A and B step the Max RPM gear, fire D flips the Power Drive gear bit
 */
`timescale 1ns/1ps

module gear_counter (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  cabinet_ctrl_pkg::player_ctrl_t ctrl_p1_i,
	input  cabinet_ctrl_pkg::player_ctrl_t ctrl_p2_i,
	output cabinet_game_pkg::gear_t        maxrpm_gear1_o,
	output cabinet_game_pkg::gear_t        maxrpm_gear2_o,
	output logic [1:0]                     powerdrv_gear_o
);

	cabinet_ctrl_pkg::player_ctrl_t ctrl [2];
	cabinet_game_pkg::gear_t        gear_q [2];
	logic [1:0]                     fire_a_q;  // Previous levels
	logic [1:0]                     fire_b_q;
	logic [1:0]                     fire_d_q;
	logic [1:0]                     rise_a;
	logic [1:0]                     rise_b;
	logic [1:0]                     rise_d;
	logic [1:0]                     toggle_q;

	assign ctrl[0] = ctrl_p1_i;
	assign ctrl[1] = ctrl_p2_i;

	// ====================
	// Edge detect per player
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			rise_a[i] = ctrl[i][cabinet_ctrl_pkg::BTN_FIRE_A] & ~fire_a_q[i];
			rise_b[i] = ctrl[i][cabinet_ctrl_pkg::BTN_FIRE_B] & ~fire_b_q[i];
			rise_d[i] = ctrl[i][cabinet_ctrl_pkg::BTN_FIRE_D] & ~fire_d_q[i];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			gear_q[0] <= '0;
			gear_q[1] <= '0;
			fire_a_q  <= '0;
			fire_b_q  <= '0;
			fire_d_q  <= '0;
			toggle_q  <= '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				fire_a_q[i] <= ctrl[i][cabinet_ctrl_pkg::BTN_FIRE_A];
				fire_b_q[i] <= ctrl[i][cabinet_ctrl_pkg::BTN_FIRE_B];
				fire_d_q[i] <= ctrl[i][cabinet_ctrl_pkg::BTN_FIRE_D];

				if (ctrl[i][cabinet_ctrl_pkg::BTN_START])  // Start puts it back in neutral
					gear_q[i] <= '0;
				else if (rise_a[i] && gear_q[i] != cabinet_game_pkg::GEAR_MAX)
					gear_q[i] <= gear_q[i] + 1'b1;
				else if (rise_b[i] && gear_q[i] != '0)
					gear_q[i] <= gear_q[i] - 1'b1;

				if (rise_d[i])
					toggle_q[i] <= ~toggle_q[i];
			end
		end
	end

	assign maxrpm_gear1_o  = gear_q[0];
	assign maxrpm_gear2_o  = gear_q[1];
	assign powerdrv_gear_o = toggle_q;

endmodule

/* logic/input_port_map.sv */
/*
 * Game specific layout of the five active-low CPU input bytes
 * Bytes 0 to 3 are registered, input3 carries the DIP switches, input4 is idle
 */
`timescale 1ns/1ps

module input_port_map (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  cabinet_game_pkg::game_e        game_i,
	input  logic                           service_i,
	input  cabinet_ctrl_pkg::port_byte_t   dip_i,
	input  cabinet_ctrl_pkg::player_ctrl_t ctrl_p1_i,
	input  cabinet_ctrl_pkg::player_ctrl_t ctrl_p2_i,
	input  cabinet_game_pkg::gear_t        maxrpm_gear1_i,
	input  cabinet_game_pkg::gear_t        maxrpm_gear2_i,
	input  logic [1:0]                     powerdrv_gear_i,
	output cabinet_ctrl_pkg::port_byte_t   input0_o,
	output cabinet_ctrl_pkg::port_byte_t   input1_o,
	output cabinet_ctrl_pkg::port_byte_t   input2_o,
	output cabinet_ctrl_pkg::port_byte_t   input3_o,
	output cabinet_ctrl_pkg::port_byte_t   input4_o
);

	// Index 0 is player 1, index 1 player 2
	logic [1:0] fire_a, fire_b, fire_c, up, down, left, right, start, coin;
	cabinet_ctrl_pkg::port_byte_t byte0_d, byte1_d, byte2_d;

	assign fire_a = {ctrl_p2_i[cabinet_ctrl_pkg::BTN_FIRE_A], ctrl_p1_i[cabinet_ctrl_pkg::BTN_FIRE_A]};
	assign fire_b = {ctrl_p2_i[cabinet_ctrl_pkg::BTN_FIRE_B], ctrl_p1_i[cabinet_ctrl_pkg::BTN_FIRE_B]};
	assign fire_c = {ctrl_p2_i[cabinet_ctrl_pkg::BTN_FIRE_C], ctrl_p1_i[cabinet_ctrl_pkg::BTN_FIRE_C]};
	assign up     = {ctrl_p2_i[cabinet_ctrl_pkg::BTN_UP], ctrl_p1_i[cabinet_ctrl_pkg::BTN_UP]};
	assign down   = {ctrl_p2_i[cabinet_ctrl_pkg::BTN_DOWN], ctrl_p1_i[cabinet_ctrl_pkg::BTN_DOWN]};
	assign left   = {ctrl_p2_i[cabinet_ctrl_pkg::BTN_LEFT], ctrl_p1_i[cabinet_ctrl_pkg::BTN_LEFT]};
	assign right  = {ctrl_p2_i[cabinet_ctrl_pkg::BTN_RIGHT], ctrl_p1_i[cabinet_ctrl_pkg::BTN_RIGHT]};
	assign start  = {ctrl_p2_i[cabinet_ctrl_pkg::BTN_START], ctrl_p1_i[cabinet_ctrl_pkg::BTN_START]};
	assign coin   = {ctrl_p2_i[cabinet_ctrl_pkg::BTN_COIN], ctrl_p1_i[cabinet_ctrl_pkg::BTN_COIN]};

	always_comb begin
		byte0_d = cabinet_game_pkg::PORT_IDLE;
		byte1_d = cabinet_game_pkg::PORT_IDLE;
		byte2_d = cabinet_game_pkg::PORT_IDLE;
		case (game_i)
			cabinet_game_pkg::RAMPAGE: begin
				byte0_d = ~{2'b00, service_i, 3'b000, coin[1], coin[0]};
				byte1_d = ~{2'b00, fire_b[0], fire_a[0], left[0], down[0], right[0], up[0]};
				byte2_d = ~{2'b00, fire_b[1], fire_a[1], left[1], down[1], right[1], up[1]};
			end
			cabinet_game_pkg::SARGE: begin
				byte0_d = ~{2'b00, service_i, 1'b0, start[1], start[0], coin[1], coin[0]};
				byte1_d = ~{{2{fire_a[0] | fire_b[0]}}, {2{fire_a[1] | fire_b[1]}},
					down[0], up[0], down[1], up[1]};
			end
			cabinet_game_pkg::MAXRPM: begin
				byte0_d = ~{service_i, 3'b000, start[0], start[1], coin[0], coin[1]};
				byte2_d = ~{cabinet_game_pkg::MAXRPM_GEAR_BITS[maxrpm_gear1_i],
					cabinet_game_pkg::MAXRPM_GEAR_BITS[maxrpm_gear2_i]};
			end
			default: begin  // Power Drive
				byte0_d = ~{2'b00, service_i, 3'b000, coin[1], coin[0]};
				byte1_d = ~{fire_b[1], fire_a[1], powerdrv_gear_i[1], fire_c[1],
					fire_b[0], fire_a[0], powerdrv_gear_i[0], fire_c[0]};
			end
		endcase
	end

	assign input4_o = cabinet_game_pkg::PORT_IDLE;  // Third player port, unused

	always_ff @(posedge clk_sys) begin
		input3_o <= dip_i;  // Follows the switches through reset
		if (reset) begin
			input0_o <= cabinet_game_pkg::PORT_IDLE;
			input1_o <= cabinet_game_pkg::PORT_IDLE;
			input2_o <= cabinet_game_pkg::PORT_IDLE;
		end else begin
			input0_o <= byte0_d;
			input1_o <= byte1_d;
			input2_o <= byte2_d;
		end
	end

endmodule

/* logic/ps2_key_decoder.sv */
/*
 * PS/2 keyboard decoder, turns press and release events into held button levels
 * A new event is flagged by a change of the strobe bit
 */
`timescale 1ns/1ps

module ps2_key_decoder (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  cabinet_ctrl_pkg::ps2_event_t   ps2_key_i,
	output cabinet_ctrl_pkg::player_ctrl_t kbd_p1_o,
	output cabinet_ctrl_pkg::player_ctrl_t kbd_p2_o
);

	logic                           strobe_q;
	logic                           pressed;
	logic                           esc_q;  // Shared coin
	cabinet_ctrl_pkg::player_ctrl_t p1_q;
	cabinet_ctrl_pkg::player_ctrl_t p2_q;

	assign pressed = ps2_key_i[cabinet_ctrl_pkg::PS2_PRESSED];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			strobe_q <= ps2_key_i[cabinet_ctrl_pkg::PS2_STROBE];  // No event on leaving reset
			esc_q    <= 1'b0;
			p1_q     <= '0;
			p2_q     <= '0;
		end else begin
			strobe_q <= ps2_key_i[cabinet_ctrl_pkg::PS2_STROBE];
			if (strobe_q != ps2_key_i[cabinet_ctrl_pkg::PS2_STROBE]) begin
				// Extended flag ignored, so right Alt and Ctrl also count
				case (ps2_key_i[7:0])
					8'h75: p1_q[cabinet_ctrl_pkg::BTN_UP]     <= pressed;  // Arrow up
					8'h72: p1_q[cabinet_ctrl_pkg::BTN_DOWN]   <= pressed;  // Arrow down
					8'h6B: p1_q[cabinet_ctrl_pkg::BTN_LEFT]   <= pressed;  // Arrow left
					8'h74: p1_q[cabinet_ctrl_pkg::BTN_RIGHT]  <= pressed;  // Arrow right
					8'h29: p1_q[cabinet_ctrl_pkg::BTN_FIRE_A] <= pressed;  // Space
					8'h11: p1_q[cabinet_ctrl_pkg::BTN_FIRE_B] <= pressed;  // Alt
					8'h14: p1_q[cabinet_ctrl_pkg::BTN_FIRE_C] <= pressed;  // Ctrl
					8'h12: p1_q[cabinet_ctrl_pkg::BTN_FIRE_D] <= pressed;  // Left shift
					8'h16: p1_q[cabinet_ctrl_pkg::BTN_START]  <= pressed;  // 1
					8'h2E: p1_q[cabinet_ctrl_pkg::BTN_COIN]   <= pressed;  // 5
					8'h2D: p2_q[cabinet_ctrl_pkg::BTN_UP]     <= pressed;  // R
					8'h2B: p2_q[cabinet_ctrl_pkg::BTN_DOWN]   <= pressed;  // F
					8'h23: p2_q[cabinet_ctrl_pkg::BTN_LEFT]   <= pressed;  // D
					8'h34: p2_q[cabinet_ctrl_pkg::BTN_RIGHT]  <= pressed;  // G
					8'h1C: p2_q[cabinet_ctrl_pkg::BTN_FIRE_A] <= pressed;  // A
					8'h1B: p2_q[cabinet_ctrl_pkg::BTN_FIRE_B] <= pressed;  // S
					8'h15: p2_q[cabinet_ctrl_pkg::BTN_FIRE_C] <= pressed;  // Q
					8'h1D: p2_q[cabinet_ctrl_pkg::BTN_FIRE_D] <= pressed;  // W
					8'h1E: p2_q[cabinet_ctrl_pkg::BTN_START]  <= pressed;  // 2
					8'h36: p2_q[cabinet_ctrl_pkg::BTN_COIN]   <= pressed;  // 6
					8'h76: esc_q                              <= pressed;  // Escape
					default: ;  // Other keys ignored
				endcase
			end
		end
	end

	// Escape kept apart so releasing it leaves a held 5 or 6 alone
	assign kbd_p1_o = p1_q | (cabinet_ctrl_pkg::player_ctrl_t'(esc_q) << cabinet_ctrl_pkg::BTN_COIN);
	assign kbd_p2_o = p2_q | (cabinet_ctrl_pkg::player_ctrl_t'(esc_q) << cabinet_ctrl_pkg::BTN_COIN);

endmodule

/* verif/cabinet_checker.sv */
/*
 * Compares the DUT input bytes with the expected values on request
 * Also checks the values right after reset and keeps the counts
 */
`timescale 1ns/1ps

module cabinet_checker (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       check_i,
	input  logic [7:0] exp0_i,
	input  logic [7:0] exp1_i,
	input  logic [7:0] exp2_i,
	input  logic [7:0] exp3_i,
	input  logic [7:0] exp4_i,
	input  logic [7:0] dip_i,
	input  logic       splitter_select_i,
	input  logic [7:0] input0_i,
	input  logic [7:0] input1_i,
	input  logic [7:0] input2_i,
	input  logic [7:0] input3_i,
	input  logic [7:0] input4_i,
	output int         errors_o,
	output int         checks_o
);

	logic reset_q = 1'b0;

	initial begin
		errors_o = 0;
		checks_o = 0;
	end

	task automatic compare_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks_o++;
		if (got !== exp) begin
			errors_o++;
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// Values seen at a rising edge are the ones settled since the previous edge
	always @(posedge clk_sys) begin
		reset_q <= reset;
		if (reset_q && !reset) begin  // First edge out of reset
			compare_byte("input0 after reset", input0_i, 8'hFF);
			compare_byte("input1 after reset", input1_i, 8'hFF);
			compare_byte("input2 after reset", input2_i, 8'hFF);
			compare_byte("input3 after reset", input3_i, dip_i);
			compare_byte("input4 after reset", input4_i, 8'hFF);
			compare_byte("splitter select after reset", {7'd0, splitter_select_i}, 8'h01);
		end
		if (check_i) begin
			compare_byte("input0", input0_i, exp0_i);
			compare_byte("input1", input1_i, exp1_i);
			compare_byte("input2", input2_i, exp2_i);
			compare_byte("input3", input3_i, exp3_i);
			compare_byte("input4", input4_i, exp4_i);
		end
	end

endmodule

/* verif/cabinet_inputs_properties.sv */
/*
 * Concurrent assertions bound into the cabinet input top level
 */
`timescale 1ns/1ps

module cabinet_inputs_properties (
	input logic                    clk_sys,
	input logic                    reset,
	input logic                    splitter_select_i,
	input cabinet_game_pkg::gear_t gear1_i,
	input cabinet_game_pkg::gear_t gear2_i,
	input logic [7:0]              input3_i,
	input logic [7:0]              dip_i
);

	int fail_count = 0;  // Failed assertions so far

	// Splitter starts in the player 1 phase
	select_after_reset: assert property (@(posedge clk_sys) reset |=> splitter_select_i)
		else begin
			fail_count++;
			$error("splitter select low after reset");
		end

	gear_in_range: assert property (@(posedge clk_sys) disable iff (reset)
		gear1_i <= cabinet_game_pkg::GEAR_MAX && gear2_i <= cabinet_game_pkg::GEAR_MAX)
		else begin
			fail_count++;
			$error("gear above the top gear");
		end

	dip_follows: assert property (@(posedge clk_sys) disable iff (reset)
		input3_i == $past(dip_i))
		else begin
			fail_count++;
			$error("input3 does not follow the DIP byte");
		end

endmodule

/* verif/tb_cabinet_inputs.sv */
/*
 * Testbench for the cabinet input block
 * Applies a table of control steps and hands expected bytes to the checker
 */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_o,
	output logic reset_o
);

	initial begin
		clk_o   = 1'b0;
		reset_o = 1'b1;
		forever #10 clk_o = ~clk_o;  // 20 ns period
	end

	initial begin
		repeat (3) @(posedge clk_o);
		@(negedge clk_o);
		reset_o = 1'b0;
	end

endmodule

module tb_cabinet_inputs;

	localparam logic [31:0] SEED = 32'h2914838e;

	typedef struct packed {
		logic [1:0]  game;
		logic [9:0]  pad0;
		logic [9:0]  pad1;
		logic [9:0]  key;    // Send, pressed, scancode
		logic [5:0]  db9_a;  // Player 1 phase in splitter mode
		logic [5:0]  db9_b;
		logic [1:0]  mode;
		logic        swap;
		logic        service;
		logic [31:0] exp;    // Bytes 0, 1, 2, 4
	} step_t;

	logic                           clk_sys;
	logic                           reset;
	cabinet_ctrl_pkg::ps2_event_t   ps2_key;
	cabinet_ctrl_pkg::player_ctrl_t pad0, pad1;
	cabinet_ctrl_pkg::db9_lines_t   db9;
	cabinet_game_pkg::db9_mode_e    db9_mode;
	cabinet_game_pkg::game_e        game;
	logic                           swap, service, splitter_select, strobe;
	cabinet_ctrl_pkg::port_byte_t   dip, in0, in1, in2, in3, in4;
	logic [7:0]                     exp0, exp1, exp2, exp3, exp4;
	logic                           check;
	int                             errors, checks, cycles, limit;
	step_t                          steps [$];

	tb_clock_gen i_clk (
		.clk_o   (clk_sys),
		.reset_o (reset)
	);

	cabinet_inputs #(
		.SPLIT_DIV (4)
	) i_dut (
		.clk_sys           (clk_sys),
		.reset             (reset),
		.ps2_key_i         (ps2_key),
		.pad0_i            (pad0),
		.pad1_i            (pad1),
		.db9_i             (db9),
		.db9_mode_i        (db9_mode),
		.swap_i            (swap),
		.game_i            (game),
		.service_i         (service),
		.dip_i             (dip),
		.splitter_select_o (splitter_select),
		.input0_o          (in0),
		.input1_o          (in1),
		.input2_o          (in2),
		.input3_o          (in3),
		.input4_o          (in4)
	);

	cabinet_checker i_checker (
		.clk_sys           (clk_sys),
		.reset             (reset),
		.check_i           (check),
		.exp0_i            (exp0),
		.exp1_i            (exp1),
		.exp2_i            (exp2),
		.exp3_i            (exp3),
		.exp4_i            (exp4),
		.dip_i             (dip),
		.splitter_select_i (splitter_select),
		.input0_i          (in0),
		.input1_i          (in1),
		.input2_i          (in2),
		.input3_i          (in3),
		.input4_i          (in4),
		.errors_o          (errors),
		.checks_o          (checks)
	);

	bind cabinet_inputs cabinet_inputs_properties i_props (
		.clk_sys           (clk_sys),
		.reset             (reset),
		.splitter_select_i (splitter_select_o),
		.gear1_i           (maxrpm_gear1),
		.gear2_i           (maxrpm_gear2),
		.input3_i          (input3_o),
		.dip_i             (dip_i)
	);

	task automatic add_step(input logic [1:0] g, input logic [9:0] p0, input logic [9:0] p1,
		input logic [9:0] k, input logic [5:0] a, input logic [5:0] b,
		input logic [1:0] m, input logic sw, input logic svc, input logic [31:0] e);
		steps.push_back('{g, p0, p1, k, a, b, m, sw, svc, e});
	endtask

	task automatic build_table();
		// ==================== Rampage, pads and keyboard
		add_step(2'd0, 10'h000, 10'h000, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFFFFFFF);
		add_step(2'd0, 10'h018, 10'h000, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFEEFFFF);
		add_step(2'd0, 10'h000, 10'h022, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFFFD7FF);
		add_step(2'd0, 10'h000, 10'h000, 10'h376, 6'h3F, 6'h3F, 2'd3, 0, 1, 32'hDCFFFFFF); // Esc
		add_step(2'd0, 10'h000, 10'h000, 10'h276, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFFFFFFF);
		add_step(2'd0, 10'h000, 10'h000, 10'h374, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFFDFFFF);
		add_step(2'd0, 10'h000, 10'h000, 10'h334, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFFDFDFF);
		add_step(2'd0, 10'h000, 10'h000, 10'h274, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFFFFDFF);
		add_step(2'd0, 10'h000, 10'h000, 10'h234, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFFFFFFF);
		add_step(2'd0, 10'h000, 10'h000, 10'h32E, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFEFFFFFF);
		add_step(2'd0, 10'h000, 10'h000, 10'h22E, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFFFFFFF);
		// ==================== DB9 modes, swap, splitter
		add_step(2'd0, 10'h000, 10'h000, 10'h000, 6'h37, 6'h3F, 2'd0, 0, 0, 32'hFFFEFFFF);
		add_step(2'd0, 10'h000, 10'h000, 10'h000, 6'h2F, 6'h3F, 2'd1, 0, 0, 32'hFFFFEFFF);
		add_step(2'd0, 10'h000, 10'h000, 10'h000, 6'h2F, 6'h3F, 2'd3, 0, 0, 32'hFFFFFFFF);
		add_step(2'd0, 10'h010, 10'h000, 10'h000, 6'h3D, 6'h3F, 2'd0, 1, 0, 32'hFFEFF7FF);
		add_step(2'd0, 10'h000, 10'h000, 10'h000, 6'h1F, 6'h3B, 2'd2, 0, 0, 32'hFFDFFBFF);
		add_step(2'd0, 10'h000, 10'h000, 10'h000, 6'h37, 6'h3E, 2'd2, 1, 0, 32'hFFFDFEFF);
		// ==================== Sarge
		add_step(2'd1, 10'h110, 10'h000, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFB3FFFFF);
		add_step(2'd1, 10'h004, 10'h128, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hF7C6FFFF);
		add_step(2'd1, 10'h000, 10'h000, 10'h336, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFDFFFFFF);
		add_step(2'd1, 10'h000, 10'h000, 10'h236, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFFFFFFF);
		// ==================== Power Drive, fire D flips the gear bit
		add_step(2'd2, 10'h080, 10'h000, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFFDFFFF);
		add_step(2'd2, 10'h040, 10'h000, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFFCFFFF);
		add_step(2'd2, 10'h080, 10'h000, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFFFFFFF);
		add_step(2'd2, 10'h000, 10'h090, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFF9FFFFF);
		add_step(2'd2, 10'h000, 10'h020, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFF5FFFFF);
		add_step(2'd2, 10'h200, 10'h040, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFECFFFFF);
		// ==================== Max RPM gears
		add_step(2'd3, 10'h100, 10'h100, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hF3FFFFFF);
		add_step(2'd3, 10'h000, 10'h000, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 1, 32'h7FFFFFFF);
		add_step(2'd3, 10'h010, 10'h000, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFFFAFFF);
		add_step(2'd3, 10'h000, 10'h000, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFFFAFFF);
		add_step(2'd3, 10'h010, 10'h000, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFFF9FFF);
		add_step(2'd3, 10'h000, 10'h000, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFFF9FFF);
		add_step(2'd3, 10'h010, 10'h000, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFFFEFFF);
		add_step(2'd3, 10'h000, 10'h000, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFFFEFFF);
		add_step(2'd3, 10'h010, 10'h000, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFFFDFFF);
		add_step(2'd3, 10'h000, 10'h000, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFFFDFFF);
		add_step(2'd3, 10'h010, 10'h000, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFFFDFFF); // Top
		add_step(2'd3, 10'h020, 10'h000, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFFFEFFF);
		add_step(2'd3, 10'h000, 10'h010, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFFFEAFF);
		add_step(2'd3, 10'h100, 10'h010, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hF7FFFAFF);
		add_step(2'd3, 10'h000, 10'h000, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFFFFAFF);
		add_step(2'd3, 10'h000, 10'h020, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFFFFFFF);
		add_step(2'd3, 10'h000, 10'h000, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFFFFFFF);
		add_step(2'd3, 10'h000, 10'h020, 10'h000, 6'h3F, 6'h3F, 2'd3, 0, 0, 32'hFFFFFFFF); // Floor
	endtask

	// Drive one step on the falling edge, wait its latency, then request a check
	task automatic run_step(input step_t s);
		game     = cabinet_game_pkg::game_e'(s.game);
		db9_mode = cabinet_game_pkg::db9_mode_e'(s.mode);
		pad0     = s.pad0;
		pad1     = s.pad1;
		db9      = s.db9_a;
		swap     = s.swap;
		service  = s.service;
		dip      = 8'($urandom);
		if (s.key[9]) begin
			strobe  = ~strobe;
			ps2_key = {strobe, s.key[8], 1'b0, s.key[7:0]};
		end
		if (s.mode == 2'd2) begin
			if (!splitter_select) begin
				@(posedge splitter_select);
				@(negedge clk_sys);
			end
			@(negedge splitter_select);  // Player 1 captured
			@(negedge clk_sys);
			db9 = s.db9_b;
			@(posedge splitter_select);  // Player 2 captured
			@(posedge clk_sys);
			@(negedge clk_sys);
		end else begin
			repeat (2) @(posedge clk_sys);
			@(negedge clk_sys);
		end
		{exp0, exp1, exp2, exp4} = s.exp;
		exp3  = dip;
		check = 1'b1;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check = 1'b0;
	endtask

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles > limit) begin
			$display("Timeout: the run did not finish within %0d cycles", limit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial begin
		void'($urandom(SEED));
		cycles   = 0;
		strobe   = 1'b0;
		ps2_key  = '0;
		pad0     = '0;
		pad1     = '0;
		db9      = '1;
		db9_mode = cabinet_game_pkg::OFF;
		swap     = 1'b0;
		game     = cabinet_game_pkg::RAMPAGE;
		service  = 1'b0;
		dip      = 8'($urandom);
		check    = 1'b0;
		{exp0, exp1, exp2, exp3, exp4} = '1;
		build_table();
		limit = steps.size() * 10 + 200;

		@(negedge reset);
		@(posedge clk_sys);  // Reset values checked here
		@(negedge clk_sys);
		foreach (steps[i])
			run_step(steps[i]);

		$display("Checks %0d, errors %0d, assertion failures %0d", checks, errors,
			i_dut.i_props.fail_count);
		if (errors == 0 && i_dut.i_props.fail_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule
